// ==== logic/frame_pkg.sv ====
// Frame package: line length, colour widths and menu status bit positions
package frame_pkg;

    // Base video line
    localparam int hlen   = 322;              // Pixels per base line
    localparam int addr_w = $clog2(hlen);     // Line buffer address width

    // Colour widths
    localparam int pxl_w  = 8;                // 3-3-2 base pixel
    localparam int vga_w  = 6;                // Per VGA channel

    // Positions in the 32-bit menu status word
    localparam int st_pause    = 1;           // Pause request
    localparam int st_level_lo = 2;           // Difficulty, bits 3:2
    localparam int st_lives_lo = 5;           // Lives, bits 6:5

    // Set means scanline filter off
    localparam int st_filter   = 9;

    localparam int st_rst_req  = 15;          // Menu reset request

endpackage

// ==== logic/cfg_decoder.sv ====
// Settings decoder: registers cabinet DIP values and filter enable from the menu word
module cfg_decoder
    import frame_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    output logic        dip_pause,
    output logic [1:0]  dip_level,
    output logic [1:0]  dip_lives,
    output logic        filter_on,
    output logic        rst_req
);

    logic [1:0] menu_level;   // Difficulty in menu order
    logic [1:0] hw_level;     // Difficulty in game encoding

    assign menu_level = status[st_level_lo +: 2];

    // Menu lists Normal first, the game expects Easy as 00
    always_comb begin
        case (menu_level)
            2'b00:   hw_level = 2'b01;  // Normal
            2'b01:   hw_level = 2'b00;  // Easy
            2'b10:   hw_level = 2'b10;  // Hard
            default: hw_level = 2'b11;  // Very hard
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dip_pause <= 1'b0;
            dip_level <= 2'b00;
            dip_lives <= 2'b00;
            filter_on <= 1'b0;
            rst_req   <= 1'b0;
        end else begin
            dip_pause <= ~status[st_pause];     // Game pause is active low
            dip_level <= hw_level;
            dip_lives <= status[st_lives_lo +: 2];
            filter_on <= ~status[st_filter];
            rst_req   <= status[st_rst_req];
        end
    end

endmodule

// ==== logic/line_doubler.sv ====
// Line doubler: ping-pong line buffer that replays each base line twice at double rate
module line_doubler
    import frame_pkg::*;
(
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic             pxl2_cen,
    input  logic [pxl_w-1:0] pxl,
    output logic [pxl_w-1:0] dbl_pxl,
    output logic             dbl_cen,
    output logic             odd_line
);

    // Two line memories, one filled while the other is played back
    logic [pxl_w-1:0]  line_mem [0:1][0:hlen-1];

    logic [addr_w-1:0] wr_cnt;
    logic [addr_w-1:0] rd_cnt;
    logic              wr_sel;      // Buffer being written
    logic              pass;        // 0 on first replay, 1 on second

    logic              wr_last;
    logic              rd_last;
    logic              wr_wrap;

    assign wr_last = wr_cnt == addr_w'(hlen - 1);
    assign rd_last = rd_cnt == addr_w'(hlen - 1);
    assign wr_wrap = pxl_cen & wr_last;

    // Write side at the base pixel rate
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            wr_cnt <= '0;
            wr_sel <= 1'b0;
        end else if (pxl_cen) begin
            if (wr_last) begin
                wr_cnt <= '0;
                wr_sel <= ~wr_sel;          // Swap buffers at end of line
            end else begin
                wr_cnt <= wr_cnt + addr_w'(1);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            line_mem[wr_sel][wr_cnt] <= pxl;
        end
    end

    // Read side at twice the base rate
    // The write wrap realigns both replays to the new line
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rd_cnt <= '0;
            pass   <= 1'b0;
        end else if (wr_wrap) begin
            rd_cnt <= '0;
            pass   <= 1'b0;
        end else if (pxl2_cen) begin
            if (rd_last) begin
                rd_cnt <= '0;
                pass   <= ~pass;
            end else begin
                rd_cnt <= rd_cnt + addr_w'(1);
            end
        end
    end

    // Playback always from the buffer not being filled
    always_ff @(posedge clk_sys) begin
        if (pxl2_cen) begin
            dbl_pxl <= line_mem[~wr_sel][rd_cnt];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dbl_cen  <= 1'b0;
            odd_line <= 1'b0;
        end else begin
            dbl_cen <= pxl2_cen;                // One cycle behind the strobe
            if (pxl2_cen) begin
                odd_line <= pass;
            end
        end
    end

endmodule

// ==== logic/colour_out.sv ====
// Colour output: widens 3-3-2 pixels to 6-6-6, applies scanlines, registers VGA pins
module colour_out
    import frame_pkg::*;
(
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             filter_on,
    input  logic [pxl_w-1:0] dbl_pxl,
    input  logic             dbl_cen,
    input  logic             odd_line,
    output logic [vga_w-1:0] vga_r,
    output logic [vga_w-1:0] vga_g,
    output logic [vga_w-1:0] vga_b,
    output logic             vga_cen
);

    logic [2:0]       red;
    logic [2:0]       green;
    logic [1:0]       blue;

    logic [vga_w-1:0] r_wide;
    logic [vga_w-1:0] g_wide;
    logic [vga_w-1:0] b_wide;
    logic             darken;

    // Pixel layout is RRRGGGBB
    assign red   = dbl_pxl[pxl_w-1 -: 3];
    assign green = dbl_pxl[pxl_w-4 -: 3];
    assign blue  = dbl_pxl[1:0];

    // Bit replication keeps full white at full scale
    assign r_wide = {red, red};
    assign g_wide = {green, green};
    assign b_wide = {3{blue}};

    // Second replay of a line is the dark scanline
    assign darken = filter_on & odd_line;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vga_r   <= '0;
            vga_g   <= '0;
            vga_b   <= '0;
            vga_cen <= 1'b0;
        end else begin
            vga_cen <= dbl_cen;
            if (dbl_cen) begin
                if (darken) begin
                    vga_r <= r_wide >> 1;       // Half brightness
                    vga_g <= g_wide >> 1;
                    vga_b <= b_wide >> 1;
                end else begin
                    vga_r <= r_wide;
                    vga_g <= g_wide;
                    vga_b <= b_wide;
                end
            end
        end
    end

endmodule

// ==== logic/popeye_vga_frame.sv ====
// Board video and settings frame: menu decoding, line doubling and VGA colour output
module popeye_vga_frame
    import frame_pkg::*;
(
    input  logic             clk_sys,
    input  logic             rst,

    // Menu status word
    input  logic [31:0]      status,

    // Base video from the game core
    input  logic             pxl_cen,
    input  logic             pxl2_cen,
    input  logic [pxl_w-1:0] pxl,

    // Cabinet settings
    output logic             dip_pause,
    output logic [1:0]       dip_level,
    output logic [1:0]       dip_lives,
    output logic             rst_req,

    // VGA colours at the doubled line rate
    output logic [vga_w-1:0] vga_r,
    output logic [vga_w-1:0] vga_g,
    output logic [vga_w-1:0] vga_b,
    output logic             vga_cen
);

    logic             filter_on;
    logic [pxl_w-1:0] dbl_pxl;
    logic             dbl_cen;
    logic             odd_line;

    cfg_decoder u_cfg (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .status    (status),
        .dip_pause (dip_pause),
        .dip_level (dip_level),
        .dip_lives (dip_lives),
        .filter_on (filter_on),
        .rst_req   (rst_req)
    );

    // Scan doubler, one line of delay
    line_doubler u_doubler (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .pxl      (pxl),
        .dbl_pxl  (dbl_pxl),
        .dbl_cen  (dbl_cen),
        .odd_line (odd_line)
    );

    colour_out u_colour (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .filter_on (filter_on),     // From the menu
        .dbl_pxl   (dbl_pxl),
        .dbl_cen   (dbl_cen),
        .odd_line  (odd_line),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_cen   (vga_cen)
    );

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock and reset generator with an 8-unit clock and a 4-cycle reset
module tb_clock (
    output logic clk_sys,
    output logic rst
);

    localparam int half_period = 4;
    localparam int rst_cycles  = 4;

    initial begin
        clk_sys = 1'b0;
        forever begin
            #half_period clk_sys = ~clk_sys;
        end
    end

    initial begin
        rst <= 1'b1;
        repeat (rst_cycles) @(posedge clk_sys);
        rst <= 1'b0;                            // Released on a rising edge
    end

endmodule

// ==== verification/popeye_vga_frame_assert.sv ====
// Output checks for the video frame, bound into the top level and reporting through assertions
module popeye_vga_frame_assert
    import frame_pkg::*;
(
    input logic             clk_sys,
    input logic             rst,
    input logic [31:0]      status,
    input logic             pxl_cen,
    input logic             pxl2_cen,
    input logic [pxl_w-1:0] pxl,
    input logic             dip_pause,
    input logic [1:0]       dip_level,
    input logic [1:0]       dip_lives,
    input logic             rst_req,
    input logic [vga_w-1:0] vga_r,
    input logic [vga_w-1:0] vga_g,
    input logic [vga_w-1:0] vga_b,
    input logic             vga_cen
);

    localparam int rd_w = $clog2(2 * hlen);    // Counts both replays of a line

    // Reference line buffers, filled from the core's pixel stream
    logic [pxl_w-1:0]  ref_mem [0:1][0:hlen-1];
    logic [addr_w-1:0] ref_wr;
    logic [rd_w-1:0]   ref_rd;                 // Double rate strobes since the last wrap
    logic              ref_sel;
    logic              ref_wrap;
    logic              line_done;              // A full line is stored
    logic              seen_strobe;

    logic              second_pass;
    logic [addr_w-1:0] rd_pos;
    logic [pxl_w-1:0]  stored;
    logic              dark;
    logic [vga_w-1:0]  full_r;
    logic [vga_w-1:0]  full_g;
    logic [vga_w-1:0]  full_b;
    logic [vga_w-1:0]  want_r;
    logic [vga_w-1:0]  want_g;
    logic [vga_w-1:0]  want_b;

    // Expected colour, two stages to line up with vga_cen
    logic              e1_chk;
    logic              e2_chk;
    logic [vga_w-1:0]  e1_r;
    logic [vga_w-1:0]  e1_g;
    logic [vga_w-1:0]  e1_b;
    logic [vga_w-1:0]  e2_r;
    logic [vga_w-1:0]  e2_g;
    logic [vga_w-1:0]  e2_b;

    logic              cen_d1;
    logic              cen_d2;
    logic [31:0]       status_q;
    logic              status_ok;

    // Latched by a failing assertion
    logic bad_quiet  = 1'b0;
    logic bad_cen    = 1'b0;
    logic bad_colour = 1'b0;
    logic bad_pause  = 1'b0;
    logic bad_level  = 1'b0;
    logic bad_lives  = 1'b0;
    logic bad_rstreq = 1'b0;
    logic failed;

    assign failed = bad_quiet | bad_cen | bad_colour | bad_pause | bad_level
                  | bad_lives | bad_rstreq;

    // abc becomes abcabc
    function automatic logic [vga_w-1:0] widen3(input logic [2:0] c);
        return vga_w'(c) * vga_w'(9);
    endfunction

    // ab becomes ababab
    function automatic logic [vga_w-1:0] widen2(input logic [1:0] c);
        return vga_w'(c) * vga_w'(21);
    endfunction

    // Menu order swaps the two lowest difficulty codes
    function automatic logic [1:0] level_remap(input logic [1:0] menu);
        return menu ^ {1'b0, ~menu[1]};
    endfunction

    assign ref_wrap = pxl_cen && ref_wr == addr_w'(hlen - 1);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ref_wr      <= '0;
            ref_sel     <= 1'b0;
            ref_rd      <= '0;
            line_done   <= 1'b0;
            seen_strobe <= 1'b0;
        end else begin
            if (pxl_cen) begin
                ref_wr <= ref_wrap ? '0 : ref_wr + addr_w'(1);
            end
            if (ref_wrap) begin
                ref_sel   <= ~ref_sel;
                ref_rd    <= '0;
                line_done <= 1'b1;
            end else if (pxl2_cen) begin
                ref_rd <= ref_rd + rd_w'(1);
            end
            if (pxl2_cen) begin
                seen_strobe <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            ref_mem[ref_sel][ref_wr] <= pxl;
        end
    end

    // Pixel due at this strobe, from the line finished last
    assign second_pass = ref_rd >= rd_w'(hlen);
    assign rd_pos      = second_pass ? addr_w'(ref_rd - rd_w'(hlen)) : addr_w'(ref_rd);
    assign stored      = ref_mem[~ref_sel][rd_pos];
    assign dark        = second_pass & ~status[st_filter];

    assign full_r = widen3(stored[pxl_w-1 -: 3]);
    assign full_g = widen3(stored[pxl_w-4 -: 3]);
    assign full_b = widen2(stored[1:0]);
    assign want_r = dark ? full_r >> 1 : full_r;
    assign want_g = dark ? full_g >> 1 : full_g;
    assign want_b = dark ? full_b >> 1 : full_b;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            e1_chk    <= 1'b0;
            e2_chk    <= 1'b0;
            cen_d1    <= 1'b0;
            cen_d2    <= 1'b0;
            status_ok <= 1'b0;
        end else begin
            e1_chk    <= pxl2_cen & line_done;
            e2_chk    <= e1_chk;
            cen_d1    <= pxl2_cen;
            cen_d2    <= cen_d1;
            status_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        e1_r     <= want_r;
        e1_g     <= want_g;
        e1_b     <= want_b;
        e2_r     <= e1_r;
        e2_g     <= e1_g;
        e2_b     <= e1_b;
        status_q <= status;
    end

    quiet_after_reset: assert property (@(posedge clk_sys)
        !rst && !seen_strobe |->
            !vga_cen && vga_r == '0 && vga_g == '0 && vga_b == '0 && !rst_req)
    else begin
        bad_quiet <= 1'b1;
        $error("ERR quiet after reset vga_cen=%h vga_r=%h vga_g=%h vga_b=%h rst_req=%h",
               vga_cen, vga_r, vga_g, vga_b, rst_req);
    end

    cen_latency: assert property (@(posedge clk_sys) disable iff (rst)
        vga_cen == cen_d2)
    else begin
        bad_cen <= 1'b1;
        $error("ERR vga_cen exp %h got %h", cen_d2, vga_cen);
    end

    colour_value: assert property (@(posedge clk_sys) disable iff (rst)
        e2_chk |-> vga_r == e2_r && vga_g == e2_g && vga_b == e2_b)
    else begin
        bad_colour <= 1'b1;
        $error("ERR vga_r exp %h got %h, vga_g exp %h got %h, vga_b exp %h got %h",
               e2_r, vga_r, e2_g, vga_g, e2_b, vga_b);
    end

    pause_decode: assert property (@(posedge clk_sys) disable iff (rst)
        status_ok |-> dip_pause == ~status_q[st_pause])
    else begin
        bad_pause <= 1'b1;
        $error("ERR dip_pause exp %h got %h", ~status_q[st_pause], dip_pause);
    end

    level_decode: assert property (@(posedge clk_sys) disable iff (rst)
        status_ok |-> dip_level == level_remap(status_q[st_level_lo +: 2]))
    else begin
        bad_level <= 1'b1;
        $error("ERR dip_level exp %h got %h",
               level_remap(status_q[st_level_lo +: 2]), dip_level);
    end

    lives_decode: assert property (@(posedge clk_sys) disable iff (rst)
        status_ok |-> dip_lives == status_q[st_lives_lo +: 2])
    else begin
        bad_lives <= 1'b1;
        $error("ERR dip_lives exp %h got %h", status_q[st_lives_lo +: 2], dip_lives);
    end

    rst_req_decode: assert property (@(posedge clk_sys) disable iff (rst)
        status_ok |-> rst_req == status_q[st_rst_req])
    else begin
        bad_rstreq <= 1'b1;
        $error("ERR rst_req exp %h got %h", status_q[st_rst_req], rst_req);
    end

endmodule

bind popeye_vga_frame popeye_vga_frame_assert checks (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .status    (status),
    .pxl_cen   (pxl_cen),
    .pxl2_cen  (pxl2_cen),
    .pxl       (pxl),
    .dip_pause (dip_pause),
    .dip_level (dip_level),
    .dip_lives (dip_lives),
    .rst_req   (rst_req),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_cen   (vga_cen)
);

// ==== verification/tb_popeye_vga_frame.sv ====
// Testbench top for the video frame with menu word and base pixel stimulus, watchdog and verdict
module tb_popeye_vga_frame
    import frame_pkg::*;
();

    localparam logic [31:0] lfsr_seed   = 32'h09a62b3e;
    localparam int          n_lines     = 5;
    localparam int          line_cycles = hlen * 4;    // pxl_cen is one cycle in four
    localparam int          status_gap  = 300;         // Cycles between settings changes

    // One base line more than the stimulus, plus slack for reset and the pipeline
    localparam int          watchdog_cycles = (n_lines + 1) * line_cycles + 200;

    logic             clk_sys;
    logic             rst;
    logic [31:0]      status;
    logic             pxl_cen;
    logic             pxl2_cen;
    logic [pxl_w-1:0] pxl;
    logic             dip_pause;
    logic [1:0]       dip_level;
    logic [1:0]       dip_lives;
    logic             rst_req;
    logic [vga_w-1:0] vga_r;
    logic [vga_w-1:0] vga_g;
    logic [vga_w-1:0] vga_b;
    logic             vga_cen;
    logic [31:0]      lfsr_state;

    tb_clock u_clock (
        .clk_sys (clk_sys),
        .rst     (rst)
    );

    popeye_vga_frame dut (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .status    (status),
        .pxl_cen   (pxl_cen),
        .pxl2_cen  (pxl2_cen),
        .pxl       (pxl),
        .dip_pause (dip_pause),
        .dip_level (dip_level),
        .dip_lives (dip_lives),
        .rst_req   (rst_req),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_cen   (vga_cen)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] v;
        int         i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input string why);
        $display("FAIL: see errors above");
        $fatal(1, "%s", why);
    endtask

    initial begin : stimulus
        logic [1:0] phase;
        logic [1:0] level;
        logic [7:0] bits;
        int         line;
        int         cyc;

        status     <= '0;
        pxl_cen    <= 1'b0;
        pxl2_cen   <= 1'b0;
        pxl        <= '0;
        lfsr_state = lfsr_seed;
        phase      = 2'd0;
        level      = 2'd0;

        @(posedge clk_sys);
        while (rst) begin
            @(posedge clk_sys);
        end

        for (line = 0; line < n_lines; line++) begin
            for (cyc = 0; cyc < line_cycles; cyc++) begin
                pxl_cen  <= phase == 2'd0;
                pxl2_cen <= ~phase[0];              // Also high with pxl_cen
                if (phase == 2'd0) begin
                    pxl <= draw_bits(pxl_w);
                end
                if (cyc == 0) begin
                    status[st_filter] <= ~status[st_filter];
                end
                if (cyc % status_gap == status_gap / 2) begin
                    bits = draw_bits(4);
                    status[st_level_lo +: 2] <= level;
                    status[st_pause]         <= bits[0];
                    status[st_lives_lo +: 2] <= bits[2:1];
                    status[st_rst_req]       <= bits[3];
                    level = level + 2'd1;           // Walk all difficulty codes
                end
                phase = phase + 2'd1;
                @(posedge clk_sys);
            end
        end

        pxl_cen  <= 1'b0;
        pxl2_cen <= 1'b0;
        repeat (6) @(posedge clk_sys);              // Drain the output pipeline

        if (dut.checks.failed) begin
            report_failure("a check on the DUT outputs failed at the end of the run");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // Stop at the first assertion failure
    always @(posedge clk_sys) begin
        if (dut.checks.failed) begin
            report_failure("a check on the DUT outputs failed");
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_sys);
        report_failure("timeout, the stimulus did not complete in time");
    end

endmodule

// ==== popeye_vga_frame.f ====
logic/frame_pkg.sv
logic/cfg_decoder.sv
logic/line_doubler.sv
logic/colour_out.sv
logic/popeye_vga_frame.sv
verification/tb_clock.sv
verification/popeye_vga_frame_assert.sv
verification/tb_popeye_vga_frame.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the video frame testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_popeye_vga_frame \
    --Mdir obj_dir \
    -f popeye_vga_frame.f

# Let assertion errors reach the testbench so it can report the failure itself
./obj_dir/Vtb_popeye_vga_frame +verilator+error+limit+1000
